/* approx_div_top.f */
+incdir+include
source/apb_pkg.sv
source/div_pkg.sv
source/apb_div_regs.sv
source/div_operand_stage.sv
source/div_array_triangular.sv
source/div_result_stage.sv
source/approx_div_top.sv
test/approx_div_properties.sv
test/approx_div_tb.sv

/* include/div_params.svh */
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// Operand widths
`define DIV_N_WIDTH 16
`define DIV_D_WIDTH 8

// Rows plus columns below this count use the approximate cell
`define DIV_APPROX_DEPTH 4

// Byte offsets on the APB side
`define APB_ADDR_WIDTH 8

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the approximate divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module approx_div_tb \
    -f approx_div_top.f --Mdir obj_dir -o approx_div_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/approx_div_sim)
run_status=$?
printf '%s\n' "$output"

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* source/apb_div_regs.sv */
`include "div_params.svh"

module apb_div_regs
  import apb_pkg::*, div_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  apb_req_t     req,
  output logic [31:0]  prdata,
  output logic         pready,
  output logic         pslverr,
  output div_operand_t op,
  output logic         op_valid,
  input  div_result_t  res,
  input  logic         res_valid
);

  logic [`DIV_N_WIDTH-1:0] dividend_q;
  logic [`DIV_D_WIDTH-1:0] divisor_q;
  logic                    approx_en_q;
  div_result_t             result_q;
  logic                    done_q;

  apb_reg_e   addr;
  logic       access;
  logic       err;
  logic       wr_access;
  logic       rd_access;
  logic       launch;
  ctrl_reg_t  ctrl_wr;
  ctrl_reg_t  ctrl_rd;
  cell_mode_e wr_mode;

  assign access    = req.psel & req.penable;
  assign addr      = apb_reg_e'(req.paddr);
  assign wr_access = access & req.pwrite & ~err;
  assign rd_access = access & ~req.pwrite & ~err;
  assign ctrl_wr   = ctrl_reg_t'(req.pwdata);
  assign launch    = wr_access && (addr == REG_CTRL) && ctrl_wr.start;

  // A start write takes the mode written alongside it
  assign wr_mode = ctrl_wr.approx_en ? MODE_APPROX : MODE_EXACT;

  always_comb begin
    case (addr)
      REG_DIVIDEND, REG_DIVISOR, REG_CTRL: err = 1'b0;
      REG_STATUS, REG_RESULT:              err = req.pwrite; // Read only
      default:                             err = 1'b1;
    endcase
  end

  assign pready  = 1'b1;
  assign pslverr = access & err;

  always_comb begin
    ctrl_rd           = '0;
    ctrl_rd.approx_en = approx_en_q;
  end

  always_comb begin
    prdata = '0;
    if (rd_access) begin
      case (addr)
        REG_DIVIDEND: prdata = 32'(dividend_q);
        REG_DIVISOR:  prdata = 32'(divisor_q);
        REG_CTRL:     prdata = ctrl_rd;   // Start always reads back 0
        REG_STATUS: begin
          prdata = 32'({result_q.flags.overflow, result_q.flags.div_by_zero, done_q});
        end
        REG_RESULT:   prdata = 32'({result_q.remainder, result_q.quotient});
        default:      prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dividend_q  <= '0;
      divisor_q   <= '0;
      approx_en_q <= 1'b0;
      op_valid    <= 1'b0;
      result_q    <= '0;
      done_q      <= 1'b0;
    end else begin
      op_valid <= launch;
      if (wr_access) begin
        case (addr)
          REG_DIVIDEND: dividend_q  <= req.pwdata[`DIV_N_WIDTH-1:0];
          REG_DIVISOR:  divisor_q   <= req.pwdata[`DIV_D_WIDTH-1:0];
          REG_CTRL:     approx_en_q <= ctrl_wr.approx_en;
          default:      ;
        endcase
      end
      if (rd_access && addr == REG_STATUS) begin
        done_q <= 1'b0;
      end
      // A new result wins over a clearing read in the same cycle
      if (res_valid) begin
        result_q <= res;
        done_q   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      op.dividend <= dividend_q;
      op.divisor  <= divisor_q;
      op.mode     <= wr_mode;
    end
  end

endmodule

/* source/apb_pkg.sv */
`include "div_params.svh"

package apb_pkg;

  // Register map, byte offsets
  typedef enum logic [`APB_ADDR_WIDTH-1:0] {
    REG_DIVIDEND = 'h00,
    REG_DIVISOR  = 'h04,
    REG_CTRL     = 'h08,
    REG_STATUS   = 'h0C,
    REG_RESULT   = 'h10
  } apb_reg_e;

  typedef struct packed {
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                pwdata;
  } apb_req_t;

  // Full 32-bit view of the control register
  typedef struct packed {
    logic [29:0] rsvd;
    logic        approx_en;
    logic        start;      // Self-clearing
  } ctrl_reg_t;

endpackage

/* source/approx_div_top.sv */
`include "div_params.svh"

module approx_div_top
  import apb_pkg::*, div_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  apb_req_t    req,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  div_operand_t            op;
  logic                    op_valid;
  div_operand_t            stage_op;
  div_flags_t              stage_flags;
  logic                    stage_valid;
  logic [DIV_Q_WIDTH-1:0]  quotient;
  logic [`DIV_D_WIDTH-1:0] remainder;
  div_result_t             res;
  logic                    res_valid;

  apb_div_regs regs_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .op        (op),
    .op_valid  (op_valid),
    .res       (res),
    .res_valid (res_valid)
  );

  div_operand_stage operand_i (
    .clk         (clk),
    .reset       (reset),
    .op          (op),
    .op_valid    (op_valid),
    .stage_op    (stage_op),
    .stage_flags (stage_flags),
    .stage_valid (stage_valid)
  );

  div_array_triangular array_i (
    .stage_op  (stage_op),
    .quotient  (quotient),
    .remainder (remainder)
  );

  div_result_stage result_i (
    .clk         (clk),
    .reset       (reset),
    .quotient    (quotient),
    .remainder   (remainder),
    .stage_flags (stage_flags),
    .stage_valid (stage_valid),
    .res         (res),
    .res_valid   (res_valid)
  );

endmodule

/* source/div_array_triangular.sv */
`include "div_params.svh"

module div_cell_exact (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  assign diff  = x ^ y ^ bin;
  assign bout  = (~x & y) | (~(x ^ y) & bin);
  assign r_sub = qs ? diff : x; // Restore when the row does not subtract

endmodule

module div_cell_approx (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  // Wrong only for x=1,y=0,bin=1 and x=1,y=1,bin=1
  assign diff  = (~x & (y ^ bin)) | (x & ~y);
  assign bout  = (~x & y) | (~(x ^ y) & bin);
  assign r_sub = qs ? diff : x;

endmodule

module div_array_triangular
  import div_pkg::*;
(
  input  div_operand_t            stage_op,
  output logic [DIV_Q_WIDTH-1:0]  quotient,
  output logic [`DIV_D_WIDTH-1:0] remainder
);

  localparam int QW = DIV_Q_WIDTH;
  localparam int DW = `DIV_D_WIDTH;

  logic use_approx;

  assign use_approx = (stage_op.mode == MODE_APPROX);

  // Row QW-1 is evaluated first, row 0 leaves the remainder
  for (genvar i = 0; i < QW; i++) begin : row
    logic q_bit;
    logic top_bit;

    for (genvar j = 0; j < DW; j++) begin : col
      logic x;
      logic bin;
      logic r_sub;
      logic bout;

      if (i == QW - 1) begin : g_x_top
        assign x = stage_op.dividend[i + j];
      end else if (j == 0) begin : g_x_new
        assign x = stage_op.dividend[i];  // Next dividend bit shifted in
      end else begin : g_x_rem
        assign x = row[i + 1].col[j - 1].r_sub;
      end

      if (j == 0) begin : g_bin_first
        assign bin = 1'b0;
      end else begin : g_bin_ripple
        assign bin = col[j - 1].bout;
      end

      if (i + j < `DIV_APPROX_DEPTH) begin : g_tri
        logic r_ex;
        logic r_ap;

        // Borrow is the same in both cells
        div_cell_exact u_exact (
          .x     (x),
          .y     (stage_op.divisor[j]),
          .bin   (bin),
          .qs    (q_bit),
          .r_sub (r_ex),
          .bout  (bout)
        );

        div_cell_approx u_approx (
          .x     (x),
          .y     (stage_op.divisor[j]),
          .bin   (bin),
          .qs    (q_bit),
          .r_sub (r_ap),
          .bout  ()
        );

        assign r_sub = use_approx ? r_ap : r_ex;
      end else begin : g_exact
        div_cell_exact u_exact (
          .x     (x),
          .y     (stage_op.divisor[j]),
          .bin   (bin),
          .qs    (q_bit),
          .r_sub (r_sub),
          .bout  (bout)
        );
      end

      if (i == 0) begin : g_rem
        assign remainder[j] = r_sub;
      end
    end

    if (i == QW - 1) begin : g_top_msb
      assign top_bit = stage_op.dividend[i + DW];
    end else begin : g_top_rem
      assign top_bit = row[i + 1].col[DW - 1].r_sub;
    end

    // Subtract when the carried-in top bit is set or no borrow leaves the row
    assign q_bit       = top_bit | ~col[DW - 1].bout;
    assign quotient[i] = q_bit;
  end

endmodule

/* source/div_operand_stage.sv */
`include "div_params.svh"

module div_operand_stage
  import div_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  div_operand_t op,
  input  logic         op_valid,
  output div_operand_t stage_op,
  output div_flags_t   stage_flags,
  output logic         stage_valid
);

  div_flags_t flags;

  always_comb begin
    flags.div_by_zero = (op.divisor == '0);
    // Upper dividend byte must stay below the divisor for the quotient to fit
    flags.overflow = (op.dividend[`DIV_N_WIDTH-1 -: `DIV_D_WIDTH] >= op.divisor);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      stage_op    <= op;
      stage_flags <= flags;
    end
  end

endmodule

/* source/div_pkg.sv */
`include "div_params.svh"

package div_pkg;

  localparam int unsigned DIV_Q_WIDTH = `DIV_N_WIDTH - `DIV_D_WIDTH;

  typedef enum logic {
    MODE_EXACT  = 1'b0,
    MODE_APPROX = 1'b1
  } cell_mode_e;

  typedef struct packed {
    logic [`DIV_N_WIDTH-1:0] dividend;
    logic [`DIV_D_WIDTH-1:0] divisor;
    cell_mode_e              mode;
  } div_operand_t;

  typedef struct packed {
    logic div_by_zero;
    logic overflow;   // Quotient does not fit
  } div_flags_t;

  typedef struct packed {
    logic [DIV_Q_WIDTH-1:0]  quotient;
    logic [`DIV_D_WIDTH-1:0] remainder;
    div_flags_t              flags;
  } div_result_t;

endpackage

/* source/div_result_stage.sv */
`include "div_params.svh"

module div_result_stage
  import div_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [DIV_Q_WIDTH-1:0]  quotient,
  input  logic [`DIV_D_WIDTH-1:0] remainder,
  input  div_flags_t              stage_flags,
  input  logic                    stage_valid,
  output div_result_t             res,
  output logic                    res_valid
);

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= stage_valid; // One cycle per launched op
    end
  end

  // Array output is kept as is, even when a flag is set
  always_ff @(posedge clk) begin
    if (stage_valid) begin
      res.quotient  <= quotient;
      res.remainder <= remainder;
      res.flags     <= stage_flags;
    end
  end

endmodule

/* test/approx_div_properties.sv */
module approx_div_properties
  import apb_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input apb_req_t req,
  input logic     pslverr,
  input logic     op_valid,
  input logic     res_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  logic map_hit;
  logic ro_write;

  assign map_hit  = req.paddr inside {REG_DIVIDEND, REG_DIVISOR, REG_CTRL, REG_STATUS, REG_RESULT};
  assign ro_write = req.pwrite && (req.paddr inside {REG_STATUS, REG_RESULT});

  op_valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
    op_valid |=> !op_valid)
    else $error("op_valid stayed high for more than one cycle");

  // Operand stage plus result stage
  res_follows_op: assert property (@(posedge clk) disable iff (reset)
    op_valid |-> ##2 res_valid)
    else $error("res_valid did not follow op_valid after two cycles");

  res_has_op: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> $past(op_valid, 2))
    else $error("res_valid without op_valid two cycles earlier");

  // Error only in the access phase of an unmapped or read-only transfer
  slverr_decode: assert property (@(posedge clk) disable iff (reset)
    pslverr == (req.psel && req.penable && (!map_hit || ro_write)))
    else $error("pslverr does not match the access phase and address decode");

endmodule

bind apb_div_regs approx_div_properties props_i (
  .clk       (clk),
  .reset     (reset),
  .req       (req),
  .pslverr   (pslverr),
  .op_valid  (op_valid),
  .res_valid (res_valid)
);

/* test/approx_div_tb.sv */
`include "div_params.svh"

module approx_div_tb
  import apb_pkg::*, div_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD = 40;
  localparam int AW = `APB_ADDR_WIDTH;
  localparam int QW = `DIV_N_WIDTH - `DIV_D_WIDTH;
  localparam int DW = `DIV_D_WIDTH;
  localparam int N_FIXED = 8;
  localparam int N_RANDOM = 24;
  localparam int N_EXTRA = 2;   // Reset/error test and back-to-back test
  localparam int TIMEOUT_CYCLES = (N_FIXED + N_RANDOM + N_EXTRA) * 20 + 100;

  logic        clk;
  logic        reset;
  apb_req_t    req;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  string        names[$];
  div_operand_t ops[$];
  div_result_t  exps[$];

  int err_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int hit_y0 = 0;     // Approximate cells seeing x=1,y=0,bin=1
  int hit_y1 = 0;     // Approximate cells seeing x=1,y=1,bin=1

  approx_div_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Bit-level restoring array, row QW-1 first, with the triangle rule
  function automatic div_result_t model_div(input div_operand_t opnd);
    div_result_t     r;
    logic [DW-1:0]   x;
    logic [DW-1:0]   diffs;
    logic [DW-1:0]   row_out;
    logic            top;
    logic            b;
    logic            q;
    int              s;
    r = '0;
    row_out = '0;
    x = opnd.dividend[QW-1 +: DW];
    top = opnd.dividend[`DIV_N_WIDTH-1];
    for (int i = QW - 1; i >= 0; i--) begin
      b = 1'b0;
      for (int j = 0; j < DW; j++) begin
        s = int'(x[j]) - int'(opnd.divisor[j]) - int'(b);
        diffs[j] = s[0];
        if (opnd.mode == MODE_APPROX && i + j < `DIV_APPROX_DEPTH && x[j] && b) begin
          diffs[j] = ~diffs[j];  // Only these two input rows differ
          if (opnd.divisor[j]) hit_y1++;
          else hit_y0++;
        end
        b = (s < 0);
      end
      q = top | ~b;
      r.quotient[i] = q;
      row_out = q ? diffs : x;
      top = row_out[DW-1];
      if (i > 0) x = {row_out[DW-2:0], opnd.dividend[i-1]};
    end
    r.remainder = row_out;
    r.flags.div_by_zero = (opnd.divisor == '0);
    // Quotient needs more than DW bits once the dividend reaches divisor * 2^DW
    r.flags.overflow = (opnd.dividend >= {opnd.divisor, {DW{1'b0}}});
    return r;
  endfunction

  task automatic add_entry(input string name, input logic [15:0] n, input logic [7:0] d,
                           input cell_mode_e mode);
    div_operand_t o;
    div_result_t  e;
    logic [15:0]  qq;
    logic [15:0]  rr;
    o.dividend = n;
    o.divisor = d;
    o.mode = mode;
    e = model_div(o);
    if (mode == MODE_EXACT && !e.flags.div_by_zero && !e.flags.overflow) begin
      qq = n / {8'd0, d};   // True integer division
      rr = n % {8'd0, d};
      e.quotient = qq[7:0];
      e.remainder = rr[7:0];
    end
    names.push_back(name);
    ops.push_back(o);
    exps.push_back(e);
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic apb_access(input logic wr, input logic [AW-1:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    req.psel = 1'b1;
    req.penable = 1'b0;
    req.pwrite = wr;
    req.paddr = addr;
    req.pwdata = wdata;
    @(posedge clk);
    #1 req.penable = 1'b1;
    #(PERIOD / 2);
    while (!pready) begin
      @(posedge clk);
      #(PERIOD / 2);
    end
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    req.psel = 1'b0;
    req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [AW-1:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    apb_access(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [AW-1:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic check_result(input string name, input div_result_t exp, input div_result_t act);
    if (exp.quotient !== act.quotient || exp.remainder !== act.remainder) begin
      $display("Mismatch %s: expected q=%h r=%h, actual q=%h r=%h",
               name, exp.quotient, exp.remainder, act.quotient, act.remainder);
      err_count++;
    end
  endtask

  task automatic check_flags(input string name, input div_flags_t exp, input div_flags_t act);
    if (exp !== act) begin
      $display("Mismatch %s flags: expected dbz=%b ovf=%b, actual dbz=%b ovf=%b",
               name, exp.div_by_zero, exp.overflow, act.div_by_zero, act.overflow);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic wait_done(input string name, output logic [31:0] status);
    logic err;
    int   polls;
    polls = 0;
    status = '0;
    while (!status[0] && polls < 8) begin
      apb_read(REG_STATUS, status, err);
      polls++;
    end
    if (!status[0]) begin
      $display("Done bit never came up for test %s", name);
      err_count++;
    end
  endtask

  task automatic start_op(input div_operand_t o);
    ctrl_reg_t ctrl;
    logic      err;
    ctrl = '0;
    ctrl.start = 1'b1;
    ctrl.approx_en = (o.mode == MODE_APPROX);
    apb_write(REG_DIVIDEND, 32'(o.dividend), err);
    apb_write(REG_DIVISOR, 32'(o.divisor), err);
    apb_write(REG_CTRL, ctrl, err);
  endtask

  task automatic run_entry(input int idx);
    logic [31:0] rd;
    logic        err;
    div_result_t act;
    div_flags_t  fl;
    int          errs_before;
    errs_before = err_count;
    start_op(ops[idx]);
    wait_done(names[idx], rd);
    fl.div_by_zero = rd[1];
    fl.overflow = rd[2];
    check_flags(names[idx], exps[idx].flags, fl);
    apb_read(REG_RESULT, rd, err);
    act.quotient = rd[7:0];
    act.remainder = rd[15:8];
    act.flags = fl;
    check_result(names[idx], exps[idx], act);
    apb_read(REG_STATUS, rd, err);
    check_bit({names[idx], " done cleared"}, 1'b0, rd[0]);
    report_test(names[idx], errs_before);
  endtask

  task automatic reset_and_errors();
    logic [31:0] rd;
    logic        err;
    int          errs_before;
    errs_before = err_count;
    for (int a = 0; a <= 'h10; a += 4) begin
      apb_read(AW'(a), rd, err);
      check_word($sformatf("reset read 0x%02h", a), 32'd0, rd);
      check_bit($sformatf("reset read 0x%02h pslverr", a), 1'b0, err);
    end
    apb_write(AW'('h14), 32'h1, err);
    check_bit("write unknown offset pslverr", 1'b1, err);
    apb_read(AW'('h20), rd, err);
    check_bit("read unknown offset pslverr", 1'b1, err);
    apb_write(REG_STATUS, 32'h1, err);
    check_bit("write STATUS pslverr", 1'b1, err);
    apb_write(REG_RESULT, 32'h1, err);
    check_bit("write RESULT pslverr", 1'b1, err);
    report_test("reset_and_errors", errs_before);
  endtask

  task automatic back_to_back();
    div_operand_t o;
    div_result_t  exp;
    div_result_t  act;
    logic [31:0]  rd;
    logic [15:0]  qq;
    logic [15:0]  rr;
    logic         err;
    int           errs_before;
    errs_before = err_count;
    // Approximate row 0 turns the remainder 1 into 3 for these operands
    o.dividend = 16'h0006;
    o.divisor = 8'h05;
    o.mode = MODE_APPROX;
    start_op(o);
    apb_write(REG_CTRL, 32'h1, err);    // Exact start while the first is in flight
    qq = 16'h0006 / 16'h0005;
    rr = 16'h0006 % 16'h0005;
    exp = '0;
    exp.quotient = qq[7:0];
    exp.remainder = rr[7:0];
    wait_done("back_to_back first", rd);
    wait_done("back_to_back second", rd);
    apb_read(REG_RESULT, rd, err);
    act = '0;
    act.quotient = rd[7:0];
    act.remainder = rd[15:8];
    check_result("back_to_back", exp, act);
    report_test("back_to_back", errs_before);
  endtask

  initial begin
    integer      seed;
    logic [31:0] rnd;
    logic [7:0]  d;
    logic [15:0] n;
    cell_mode_e  m;
    seed = 96348;
    reset = 1'b1;
    req = '0;

    add_entry("exact_small", 16'd100, 8'd7, MODE_EXACT);
    add_entry("exact_max", 16'hFEFF, 8'hFF, MODE_EXACT);
    add_entry("exact_div_one", 16'h00FF, 8'h01, MODE_EXACT);
    add_entry("approx_a", 16'h1234, 8'h57, MODE_APPROX);
    add_entry("approx_b", 16'h00FF, 8'h03, MODE_APPROX);
    add_entry("approx_c", 16'h7FFF, 8'h81, MODE_APPROX);
    add_entry("div_by_zero", 16'h1234, 8'h00, MODE_EXACT);
    add_entry("overflow", 16'h9000, 8'h40, MODE_EXACT);
    for (int k = 0; k < N_RANDOM; k++) begin
      rnd = $random(seed);
      d = (rnd[7:0] == 8'd0) ? 8'd1 : rnd[7:0];
      m = (k % 2 == 1) ? MODE_APPROX : MODE_EXACT;
      n = {rnd[15:8] % d, rnd[23:16]};   // Upper byte kept below the divisor
      add_entry($sformatf("rand_%0d", k), n, d, m);
    end

    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    @(posedge clk);
    #1;

    reset_and_errors();
    foreach (ops[i]) run_entry(i);
    back_to_back();

    if (hit_y0 == 0 || hit_y1 == 0) begin
      $display("The approximate cell cases with x=1 and bin=1 were never exercised");
      err_count++;
    end
    $display("Tests run: %0d, passed: %0d, failed: %0d", pass_count + fail_count,
             pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
